// File: src/armPkg.sv
package armPkg;

   localparam int XLEN        = 32;
   localparam int RegAddrBits = 4;

   // Data-processing encoding
   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        immFlag;    // 1 = imm8 in operand2
      logic [3:0]  cmd;
      logic        setFlags;   // S bit
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand2;   // imm8 or rm in low bits
   } dpInstr_t;

   // LDR/STR encoding
   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        immFlag;
      logic        preIndex;
      logic        up;
      logic        byteFlag;
      logic        writeBack;
      logic        load;       // 1 = LDR
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] imm12;      // Zero-extended offset
   } memInstr_t;

   // B encoding
   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        brFlag;
      logic        linkFlag;
      logic [23:0] imm24;      // Signed word offset
   } brInstr_t;

   // Same word seen through each instruction class
   typedef union packed {
      dpInstr_t  dp;
      memInstr_t mem;
      brInstr_t  br;
   } instrWord_t;

   // Op field, bits 27:26
   localparam logic [1:0] OpData   = 2'b00;
   localparam logic [1:0] OpMem    = 2'b01;
   localparam logic [1:0] OpBranch = 2'b10;

   // Data-processing commands
   localparam logic [3:0] CmdAnd = 4'b0000;
   localparam logic [3:0] CmdEor = 4'b0001;
   localparam logic [3:0] CmdSub = 4'b0010;
   localparam logic [3:0] CmdAdd = 4'b0100;
   localparam logic [3:0] CmdCmp = 4'b1010;
   localparam logic [3:0] CmdOrr = 4'b1100;
   localparam logic [3:0] CmdMov = 4'b1101;
   localparam logic [3:0] CmdBic = 4'b1110;

   // Condition field
   localparam logic [3:0] CondEq = 4'b0000;
   localparam logic [3:0] CondNe = 4'b0001;
   localparam logic [3:0] CondCs = 4'b0010;
   localparam logic [3:0] CondCc = 4'b0011;
   localparam logic [3:0] CondMi = 4'b0100;
   localparam logic [3:0] CondPl = 4'b0101;
   localparam logic [3:0] CondVs = 4'b0110;
   localparam logic [3:0] CondVc = 4'b0111;
   localparam logic [3:0] CondHi = 4'b1000;
   localparam logic [3:0] CondLs = 4'b1001;
   localparam logic [3:0] CondGe = 4'b1010;
   localparam logic [3:0] CondLt = 4'b1011;
   localparam logic [3:0] CondGt = 4'b1100;
   localparam logic [3:0] CondLe = 4'b1101;
   localparam logic [3:0] CondAl = 4'b1110;

   // ALU operations
   localparam logic [2:0] AluAdd   = 3'b000;
   localparam logic [2:0] AluSub   = 3'b001;
   localparam logic [2:0] AluAnd   = 3'b010;
   localparam logic [2:0] AluOrr   = 3'b011;
   localparam logic [2:0] AluEor   = 3'b100;
   localparam logic [2:0] AluBic   = 3'b101;
   localparam logic [2:0] AluPassB = 3'b110;

   // Immediate extension modes
   localparam logic [1:0] ImmByte   = 2'b00;
   localparam logic [1:0] ImmMem    = 2'b01;
   localparam logic [1:0] ImmBranch = 2'b10;

endpackage

// File: src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import armPkg::*; (
   input  instrWord_t instr,
   output logic [1:0] flagWrite,
   output logic       branchReq,
   output logic       regWriteReq,
   output logic       memWriteReq,
   output logic       memToReg,
   output logic       aluSrc,
   output logic [1:0] immSrc,
   output logic [1:0] regSrc,
   output logic [2:0] aluControl
);

   logic aluOp;   // Data-processing class
   logic arith;   // Command touches C and V

   // Main decoder
   always_comb begin
      branchReq   = 1'b0;
      regWriteReq = 1'b0;
      memWriteReq = 1'b0;
      memToReg    = 1'b0;
      aluSrc      = 1'b0;
      immSrc      = ImmByte;
      regSrc      = 2'b00;
      aluOp       = 1'b0;
      case (instr.dp.op)
         OpData: begin
            aluSrc      = instr.dp.immFlag;             // imm8 or rm
            regWriteReq = (instr.dp.cmd != CmdCmp);     // CMP only sets flags
            aluOp       = 1'b1;
         end
         OpMem: begin
            aluSrc      = 1'b1;                         // rn + imm12
            immSrc      = ImmMem;
            regSrc      = {~instr.mem.load, 1'b0};      // STR reads rd on port 2
            memToReg    = instr.mem.load;
            regWriteReq = instr.mem.load;
            memWriteReq = ~instr.mem.load;
         end
         OpBranch: begin
            aluSrc    = 1'b1;
            immSrc    = ImmBranch;
            regSrc    = 2'b01;                          // R15 as first source
            branchReq = 1'b1;
         end
         default: begin
            branchReq = 1'b0;                           // Undefined class, no effect
         end
      endcase
   end

   // ALU decoder
   always_comb begin
      aluControl = AluAdd;                              // Address and target adds
      if (aluOp) begin
         case (instr.dp.cmd)
            CmdAdd:  aluControl = AluAdd;
            CmdSub:  aluControl = AluSub;
            CmdCmp:  aluControl = AluSub;               // Subtract, result dropped
            CmdAnd:  aluControl = AluAnd;
            CmdOrr:  aluControl = AluOrr;
            CmdEor:  aluControl = AluEor;
            CmdBic:  aluControl = AluBic;
            CmdMov:  aluControl = AluPassB;
            default: aluControl = AluAdd;
         endcase
      end
   end

   assign arith = aluOp && (instr.dp.cmd inside {CmdAdd, CmdSub, CmdCmp});

   // N,Z on any S; C,V only for arithmetic
   assign flagWrite = {aluOp & instr.dp.setFlags, arith & instr.dp.setFlags};

   // Op 11 is coprocessor space, never fed to this core
   opLegal: assert final (instr.dp.op !== 2'b11)
      else $error("instrDecoder: undefined op class 2'b11");

endmodule

// File: src/condUnit.sv
`timescale 1ns/1ps

module condUnit import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic [3:0] cond,
   input  logic [3:0] aluFlags,     // N Z C V
   input  logic [1:0] flagWrite,
   input  logic       branchReq,
   input  logic       regWriteReq,
   input  logic       memWriteReq,
   output logic       regWrite,
   output logic       memWrite,
   output logic       pcSrc
);

   logic [1:0] flagsNz;   // Stored N, Z
   logic [1:0] flagsCv;   // Stored C, V
   logic [1:0] flagEn;
   logic       neg, zero, carry, overflow;
   logic       ge;
   logic       condEx;

   // Flag halves load separately
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flagsNz <= 2'b00;
         flagsCv <= 2'b00;
      end else begin
         if (flagEn[1]) flagsNz <= aluFlags[3:2];
         if (flagEn[0]) flagsCv <= aluFlags[1:0];
      end
   end

   assign {neg, zero}      = flagsNz;
   assign {carry, overflow} = flagsCv;
   assign ge = (neg == overflow);

   // Condition check on flags from before this edge
   always_comb begin
      case (cond)
         CondEq:  condEx = zero;
         CondNe:  condEx = ~zero;
         CondCs:  condEx = carry;
         CondCc:  condEx = ~carry;
         CondMi:  condEx = neg;
         CondPl:  condEx = ~neg;
         CondVs:  condEx = overflow;
         CondVc:  condEx = ~overflow;
         CondHi:  condEx = carry & ~zero;
         CondLs:  condEx = ~carry | zero;
         CondGe:  condEx = ge;
         CondLt:  condEx = ~ge;
         CondGt:  condEx = ~zero & ge;
         CondLe:  condEx = zero | ~ge;
         CondAl:  condEx = 1'b1;
         default: condEx = 1'b0;     // 1111 unsupported
      endcase
   end

   assign flagEn   = flagWrite & {2{condEx}};
   assign regWrite = regWriteReq & condEx;
   assign memWrite = memWriteReq & condEx;
   assign pcSrc    = branchReq & condEx;

   // Reserved condition must not carry a live request
   condLegal: assert property (@(posedge clk) disable iff (reset)
      (branchReq || regWriteReq || memWriteReq) |-> cond != 4'b1111);

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic        clk,
   input  logic        writeEn,
   input  logic [3:0]  readAddr1,
   input  logic [3:0]  readAddr2,
   input  logic [3:0]  writeAddr,
   input  logic [31:0] writeValue,
   input  logic [31:0] pcPlus8,
   output logic [31:0] readValue1,
   output logic [31:0] readValue2
);

   logic [31:0] regs [15];   // R0..R14

   // R15 lives in the PC, never written here
   always_ff @(posedge clk) begin
      if (writeEn && writeAddr != 4'd15) begin
         regs[writeAddr] <= writeValue;
      end
   end

   // Combinational reads, R15 gives PC+8
   assign readValue1 = (readAddr1 == 4'd15) ? pcPlus8 : regs[readAddr1];
   assign readValue2 = (readAddr2 == 4'd15) ? pcPlus8 : regs[readAddr2];

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu import armPkg::*; (
   input  logic [XLEN-1:0] a,
   input  logic [XLEN-1:0] b,
   input  logic [2:0]      aluControl,
   output logic [XLEN-1:0] result,
   output logic [3:0]      flags      // N Z C V
);

   logic            isSub;
   logic            arith;
   logic [XLEN-1:0] condInvB;
   logic [XLEN:0]   sum;            // Extra bit holds carry out
   logic            neg, zero, carry, overflow;

   assign isSub = (aluControl == AluSub);
   assign arith = (aluControl == AluAdd) || isSub;

   // One adder, b inverted plus carry-in for subtract
   assign condInvB = isSub ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, condInvB} + {{XLEN{1'b0}}, isSub};

   always_comb begin
      case (aluControl)
         AluAdd,
         AluSub:   result = sum[XLEN-1:0];
         AluAnd:   result = a & b;
         AluOrr:   result = a | b;
         AluEor:   result = a ^ b;
         AluBic:   result = a & ~b;
         AluPassB: result = b;              // MOV
         default:  result = sum[XLEN-1:0];
      endcase
   end

   assign neg  = result[XLEN-1];
   assign zero = (result == '0);
   // C is NOT borrow on subtract, matching ARM
   assign carry = arith & sum[XLEN];
   // Operands of like sign, result of other sign
   assign overflow = arith & ~(a[XLEN-1] ^ b[XLEN-1] ^ isSub)
                           & (a[XLEN-1] ^ sum[XLEN-1]);

   assign flags = {neg, zero, carry, overflow};

endmodule

// File: src/armDatapath.sv
`timescale 1ns/1ps

module armDatapath import armPkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  instrWord_t      instr,
   input  logic [1:0]      regSrc,
   input  logic [1:0]      immSrc,
   input  logic            aluSrc,
   input  logic [2:0]      aluControl,
   input  logic            memToReg,
   input  logic            regWrite,
   input  logic            pcSrc,
   input  logic [XLEN-1:0] readData,
   output logic [XLEN-1:0] pc,
   output logic [XLEN-1:0] aluResult,
   output logic [XLEN-1:0] writeData,
   output logic [3:0]      aluFlags
);

   logic [XLEN-1:0]        pcNext, pcPlus4, pcPlus8;
   logic [XLEN-1:0]        extImm;
   logic [XLEN-1:0]        srcA, srcB;
   logic [XLEN-1:0]        result;
   logic [RegAddrBits-1:0] readAddr1, readAddr2;

   // PC register, only B redirects
   assign pcNext = pcSrc ? aluResult : pcPlus4;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) pc <= '0;
      else       pc <= pcNext;
   end

   assign pcPlus4 = pc + XLEN'(4);
   assign pcPlus8 = pcPlus4 + XLEN'(4);   // R15 view

   // Branch reads R15, store reads rd as data
   assign readAddr1 = regSrc[0] ? 4'd15 : instr.dp.rn;
   assign readAddr2 = regSrc[1] ? instr.dp.rd : instr.dp.operand2[3:0];

   regFile rf (
      .clk        (clk),
      .writeEn    (regWrite),
      .readAddr1  (readAddr1),
      .readAddr2  (readAddr2),
      .writeAddr  (instr.dp.rd),
      .writeValue (result),
      .pcPlus8    (pcPlus8),
      .readValue1 (srcA),
      .readValue2 (writeData)
   );

   always_comb begin
      case (immSrc)
         ImmByte:   extImm = {24'b0, instr.dp.operand2[7:0]};
         ImmMem:    extImm = {20'b0, instr.mem.imm12};
         ImmBranch: extImm = {{6{instr.br.imm24[23]}}, instr.br.imm24, 2'b00};  // Words to bytes
         default:   extImm = '0;
      endcase
   end

   assign srcB = aluSrc ? extImm : writeData;

   // Also forms branch target R15 + offset
   alu alu (
      .a          (srcA),
      .b          (srcB),
      .aluControl (aluControl),
      .result     (aluResult),
      .flags      (aluFlags)
   );

   assign result = memToReg ? readData : aluResult;   // LDR writeback

endmodule

// File: src/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
   parameter int dataWords = 64
) (
   input  logic        clk,
   input  logic        writeEn,
   input  logic [31:0] addr,
   input  logic [31:0] writeValue,
   output logic [31:0] readValue
);

   localparam int IdxBits = $clog2(dataWords);

   logic [31:0]        ram [dataWords];
   logic [IdxBits-1:0] wordIdx;

   // Word index wraps at depth
   assign wordIdx = addr[IdxBits+1:2];

   always_ff @(posedge clk) begin
      if (writeEn) ram[wordIdx] <= writeValue;
   end

   assign readValue = ram[wordIdx];   // Async read

   // No byte or halfword stores in this core
   storeAligned: assert property (@(posedge clk) writeEn |-> addr[1:0] == 2'b00);

endmodule

// File: src/armSystem.sv
`timescale 1ns/1ps

module armSystem import armPkg::*; #(
   parameter int dataWords = 64
) (
   input  logic            clk,
   input  logic            reset,
   input  instrWord_t      instr,
   output logic [XLEN-1:0] pc,
   output logic            memWrite,
   output logic [XLEN-1:0] dataAdr,
   output logic [XLEN-1:0] writeData
);

   // Unconditional requests from the decoder
   logic [1:0]      flagWrite;
   logic            branchReq, regWriteReq, memWriteReq;
   // Datapath selects
   logic            memToReg, aluSrc;
   logic [1:0]      immSrc, regSrc;
   logic [2:0]      aluControl;
   // Condition-gated strobes
   logic            regWrite, pcSrc;
   logic [3:0]      aluFlags;
   logic [XLEN-1:0] readData;

   instrDecoder dec (
      .instr       (instr),
      .flagWrite   (flagWrite),
      .branchReq   (branchReq),
      .regWriteReq (regWriteReq),
      .memWriteReq (memWriteReq),
      .memToReg    (memToReg),
      .aluSrc      (aluSrc),
      .immSrc      (immSrc),
      .regSrc      (regSrc),
      .aluControl  (aluControl)
   );

   condUnit cu (
      .clk         (clk),
      .reset       (reset),
      .cond        (instr.dp.cond),
      .aluFlags    (aluFlags),
      .flagWrite   (flagWrite),
      .branchReq   (branchReq),
      .regWriteReq (regWriteReq),
      .memWriteReq (memWriteReq),
      .regWrite    (regWrite),
      .memWrite    (memWrite),
      .pcSrc       (pcSrc)
   );

   armDatapath dp (
      .clk        (clk),
      .reset      (reset),
      .instr      (instr),
      .regSrc     (regSrc),
      .immSrc     (immSrc),
      .aluSrc     (aluSrc),
      .aluControl (aluControl),
      .memToReg   (memToReg),
      .regWrite   (regWrite),
      .pcSrc      (pcSrc),
      .readData   (readData),
      .pc         (pc),
      .aluResult  (dataAdr),     // ALU output is the memory address
      .writeData  (writeData),
      .aluFlags   (aluFlags)
   );

   dataMem #(.dataWords(dataWords)) dmem (
      .clk        (clk),
      .writeEn    (memWrite),
      .addr       (dataAdr),
      .writeValue (writeData),
      .readValue  (readData)
   );

endmodule

// File: bench/tb_armSystem.sv
`timescale 1ns/1ps

module tb_armSystem import armPkg::*; ();

   localparam int DataWords   = 64;
   localparam int ResetCycles = 16;
   // Words per test: reset, data processing, load/store, flags, branch
   localparam int ProgWords   = 1 + 28 + 16 + 135 + 10;
   localparam int MaxCycles   = ResetCycles + ProgWords + 100;

   logic        clk;
   logic        reset;
   instrWord_t  instr;
   logic [31:0] pc;
   logic        memWrite;
   logic [31:0] dataAdr;
   logic [31:0] writeData;

   logic [31:0] prog [256];            // Program memory, indexed by pc/4
   int          emitPtr = 0;
   int          cycles;
   logic [31:0] rngState = 32'hf270;

   // Reference model state
   logic [31:0] refPc;
   logic [31:0] refReg [15];
   logic [31:0] refMem [DataWords];
   logic        refN, refZ, refC, refV;

   armSystem #(.dataWords(DataWords)) uut (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .pc        (pc),
      .memWrite  (memWrite),
      .dataAdr   (dataAdr),
      .writeData (writeData)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] nextRand();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   // Instruction encoders
   function automatic logic [31:0] dataOp(input logic [3:0] cond, input logic [3:0] cmd,
                                          input logic s, input logic imm,
                                          input logic [3:0] rn, input logic [3:0] rd,
                                          input logic [7:0] op2);
      return {cond, 2'b00, imm, cmd, s, rn, rd, 4'b0000, op2};   // op2 = imm8 or rm
   endfunction

   function automatic logic [31:0] memOp(input logic [3:0] cond, input logic load,
                                         input logic [3:0] rn, input logic [3:0] rd,
                                         input logic [11:0] imm12);
      return {cond, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, imm12};   // Pre-index, up
   endfunction

   function automatic logic [31:0] branchOp(input logic [3:0] cond, input logic [23:0] off);
      return {cond, 2'b10, 1'b1, 1'b0, off};
   endfunction

   // ARM condition table on model flags
   function automatic logic condTrue(input logic [3:0] c);
      case (c)
         CondEq:  return refZ;
         CondNe:  return !refZ;
         CondCs:  return refC;
         CondCc:  return !refC;
         CondMi:  return refN;
         CondPl:  return !refN;
         CondVs:  return refV;
         CondVc:  return !refV;
         CondHi:  return refC && !refZ;
         CondLs:  return !refC || refZ;
         CondGe:  return refN == refV;
         CondLt:  return refN != refV;
         CondGt:  return !refZ && (refN == refV);
         CondLe:  return refZ || (refN != refV);
         default: return 1'b1;
      endcase
   endfunction

   function automatic logic [31:0] readReg(input logic [3:0] n);
      if (n == 4'd15) return refPc + 32'd8;   // R15 is PC+8
      else return refReg[n];
   endfunction

   task automatic compare(input string name, input string what,
                          input logic [31:0] expected, input logic [31:0] actual);
      if (actual !== expected) begin
         $display("** Error %s: %s expected %h, actual %h", name, what, expected, actual);
         $display("Test failed");
         $fatal(1, "Mismatch in %s", name);
      end
   endtask

   task automatic emit(input logic [31:0] w);
      prog[emitPtr] = w;
      emitPtr++;
   endtask

   // Predict one instruction, check outputs, advance model
   task automatic execute(input string name, input logic [31:0] w);
      logic        ex;
      logic [31:0] a, b, res, addr, nextPc;
      logic [32:0] wide;
      logic        c, v;
      int          idx;
      ex = condTrue(w[31:28]);
      nextPc = refPc + 32'd4;
      case (w[27:26])
         2'b00: begin
            a = readReg(w[19:16]);
            b = w[25] ? {24'b0, w[7:0]} : readReg(w[3:0]);
            c = 1'b0;
            v = 1'b0;
            case (w[24:21])
               CmdAdd: begin
                  wide = {1'b0, a} + {1'b0, b};
                  res = wide[31:0];
                  c = wide[32];
                  v = (a[31] == b[31]) && (res[31] != a[31]);
               end
               CmdSub, CmdCmp: begin
                  res = a - b;
                  c = (a >= b);                            // No borrow
                  v = (a[31] != b[31]) && (res[31] != a[31]);
               end
               CmdAnd:  res = a & b;
               CmdOrr:  res = a | b;
               CmdEor:  res = a ^ b;
               CmdBic:  res = a & ~b;
               default: res = b;                           // MOV
            endcase
            compare(name, "memWrite", 32'd0, memWrite);
            if (ex && w[20]) begin
               refN = res[31];
               refZ = (res == 32'd0);
               if (w[24:21] inside {CmdAdd, CmdSub, CmdCmp}) begin
                  refC = c;
                  refV = v;
               end
            end
            if (ex && w[24:21] != CmdCmp) refReg[w[15:12]] = res;
         end
         2'b01: begin
            addr = readReg(w[19:16]) + {20'b0, w[11:0]};
            idx = (addr >> 2) % DataWords;                 // RAM wraps at depth
            if (w[20]) begin
               compare(name, "memWrite", 32'd0, memWrite);
               if (ex) refReg[w[15:12]] = refMem[idx];
            end else begin
               compare(name, "memWrite", {31'b0, ex}, memWrite);
               if (ex) begin
                  compare(name, "dataAdr", addr, dataAdr);
                  compare(name, "writeData", readReg(w[15:12]), writeData);
                  refMem[idx] = readReg(w[15:12]);
               end
            end
         end
         default: begin
            compare(name, "memWrite", 32'd0, memWrite);
            if (ex) nextPc = refPc + 32'd8 + {{6{w[23]}}, w[23:0], 2'b00};
         end
      endcase
      refPc = nextPc;
   endtask

   // Runs from a falling edge until the model leaves the emitted program
   task automatic runProgram(input string name);
      logic [31:0] w;
      while (refPc[31:2] < emitPtr) begin
         compare(name, "pc", refPc, pc);
         w = prog[refPc[9:2]];
         instr = w;                                        // Drive on falling edge
         #1;
         execute(name, w);
         @(negedge clk);
      end
   endtask

   task automatic resetState();
      compare("resetState", "pc", 32'd0, pc);
      emit(32'h0000_0000);                                 // ANDEQ, skipped with Z clear
      runProgram("resetState");
   endtask

   task automatic dataProcessing();
      logic [3:0] cmds [6];
      cmds = '{CmdAdd, CmdSub, CmdAnd, CmdOrr, CmdEor, CmdBic};
      emit(dataOp(CondAl, CmdMov, 1'b0, 1'b1, 4'd0, 4'd0, 8'h00));   // r0 = 0, base
      for (int k = 1; k <= 3; k++) begin
         emit(dataOp(CondAl, CmdMov, 1'b0, 1'b1, 4'd0, 4'(k), 8'(nextRand())));
      end
      for (int i = 0; i < 6; i++) begin
         emit(dataOp(CondAl, cmds[i], 1'(i), 1'b0, 4'd1, 4'd5, 8'h02));   // r5 = r1 op r2
         emit(memOp(CondAl, 1'b0, 4'd0, 4'd5, 12'(i * 8)));
         emit(dataOp(CondAl, cmds[i], 1'(i), 1'b1, 4'd3, 4'd6, 8'(nextRand())));
         emit(memOp(CondAl, 1'b0, 4'd0, 4'd6, 12'(i * 8 + 4)));
      end
      runProgram("dataProcessing");
   endtask

   task automatic loadStore();
      logic [11:0] offs [4];
      for (int i = 0; i < 4; i++) begin
         offs[i] = 12'(i * 32 + (nextRand() & 7) * 4);     // Distinct aligned words
         emit(dataOp(CondAl, CmdMov, 1'b0, 1'b1, 4'd0, 4'd7, 8'(nextRand())));
         emit(memOp(CondAl, 1'b0, 4'd0, 4'd7, offs[i]));
      end
      for (int i = 0; i < 4; i++) begin
         emit(memOp(CondAl, 1'b1, 4'd0, 4'd8, offs[i]));             // LDR r8
         emit(memOp(CondAl, 1'b0, 4'd0, 4'd8, offs[i] + 12'd128));   // Copy to upper half
      end
      runProgram("loadStore");
   endtask

   // CMP ra against r2, optional logic op, then one STR per condition
   task automatic flagCase(input logic [3:0] ra, input logic [7:0] x, input logic [7:0] y,
                           input logic andAfter);
      emit(dataOp(CondAl, CmdMov, 1'b0, 1'b1, 4'd0, 4'd1, x));
      emit(dataOp(CondAl, CmdMov, 1'b0, 1'b1, 4'd0, 4'd2, y));
      emit(dataOp(CondAl, CmdCmp, 1'b1, 1'b0, ra, 4'd0, 8'h02));
      if (andAfter) begin
         emit(dataOp(CondAl, CmdAnd, 1'b1, 1'b0, 4'd1, 4'd4, 8'h02));   // ANDS keeps C and V
         emit(dataOp(CondNe, CmdMov, 1'b1, 1'b1, 4'd0, 4'd1, 8'h80));   // Skipped on Z
      end
      for (int c = 0; c < 15; c++) begin
         emit(memOp(4'(c), 1'b0, 4'd0, 4'd1, 12'(c * 4)));
      end
   endtask

   task automatic flagsConditions();
      logic [7:0] same;
      emit(dataOp(CondAl, CmdMov, 1'b0, 1'b1, 4'd0, 4'd3, 8'h80));
      for (int k = 0; k < 24; k++) begin
         emit(dataOp(CondAl, CmdAdd, 1'b0, 1'b0, 4'd3, 4'd3, 8'h03));   // r3 doubles to 2^31
      end
      for (int k = 0; k < 3; k++) begin
         flagCase(4'd1, 8'(nextRand()), 8'(nextRand()), 1'b0);
      end
      same = 8'(nextRand());
      flagCase(4'd1, same, same, 1'b0);                    // Z set
      flagCase(4'd1, 8'd3, 8'd200, 1'b0);                  // Negative, borrow
      flagCase(4'd3, 8'd2, 8'd1, 1'b1);                    // 0x80000000 - 1 overflows
      runProgram("flagsConditions");
   endtask

   task automatic branchR15();
      int off;
      off = 1 + (nextRand() & 3);
      emit(memOp(CondAl, 1'b0, 4'd0, 4'd15, 12'h0f0));     // STR r15
      emit(branchOp(CondAl, 24'(off)));
      for (int k = 0; k <= off; k++) begin
         emit(dataOp(CondAl, CmdMov, 1'b0, 1'b1, 4'd0, 4'd1, 8'hee));   // Skipped words
      end
      emit(dataOp(CondAl, CmdCmp, 1'b1, 1'b0, 4'd0, 4'd0, 8'h00));      // r0 - r0, Z set
      emit(branchOp(CondNe, 24'h000002));                  // Falls through
      emit(memOp(CondAl, 1'b0, 4'd0, 4'd15, 12'h0f4));
      runProgram("branchR15");
   endtask

   initial begin
      cycles = 0;
      while (cycles < MaxCycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: program did not finish within %0d cycles", MaxCycles);
      $display("Test failed");
      $fatal(1, "Timeout");
   end

   initial begin
      reset = 1'b1;
      instr = '0;
      refPc = 32'd0;
      refN = 1'b0;
      refZ = 1'b0;
      refC = 1'b0;
      refV = 1'b0;
      repeat (ResetCycles) @(negedge clk);
      reset = 1'b0;                                        // Released on falling edge
      resetState();
      dataProcessing();
      loadStore();
      flagsConditions();
      branchR15();
      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: tb.f
src/armPkg.sv
src/instrDecoder.sv
src/condUnit.sv
src/regFile.sv
src/alu.sv
src/armDatapath.sv
src/dataMem.sv
src/armSystem.sv
bench/tb_armSystem.sv

// File: Bender.yml
package:
  name: armSystem

sources:
  - files:
      - src/armPkg.sv
      - src/instrDecoder.sv
      - src/condUnit.sv
      - src/regFile.sv
      - src/alu.sv
      - src/armDatapath.sv
      - src/dataMem.sv
      - src/armSystem.sv
  - target: test
    files:
      - bench/tb_armSystem.sv
